// ==== src/rvDecodePkg.sv ====
package rvDecodePkg;

  typedef logic [31:0] instrT;
  typedef logic [4:0] regIdxT;
  typedef logic signed [31:0] immT;

  // Operand layout of a decoded instruction
  typedef enum logic [3:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_SH,
    FMT_CSR,
    FMT_CSRI,
    FMT_NONE
  } instrFmtT;

  typedef enum logic [6:0] {
    // RV32I base
    LUI, AUIPC, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
    SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    FENCE, ECALL, EBREAK,
    // Machine mode
    MRET, WFI,
    // M extension
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    // Zicsr
    CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
    ILLEGAL
  } mnemonicT;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

endpackage

// ==== src/decodeIf.sv ====
`timescale 1ns/10ps

interface decodeIf import rvDecodePkg::*; ();

  instrT    instr;
  mnemonicT mnemonic;
  instrFmtT fmt;
  logic     illegal;
  regIdxT   rd;
  regIdxT   rs1;
  regIdxT   rs2;
  immT      imm;

  modport ctrl (
    output instr,
    input  mnemonic, fmt, illegal, rd, rs1, rs2, imm
  );

  modport match (input instr, output mnemonic, fmt, illegal);

  modport extract (input instr, fmt, output rd, rs1, rs2, imm);

endinterface

// ==== src/opcodeMatcher.sv ====
`timescale 1ns/10ps

module opcodeMatcher import rvDecodePkg::*; #(
  parameter int XLEN = 32
) (
  decodeIf.match dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shamtOk;
  mnemonicT   mn;
  instrFmtT   fmt;

  assign opcode = dec.instr[6:0];
  assign funct3 = dec.instr[14:12];
  assign funct7 = dec.instr[31:25];

  // On RV32 bit 25 would be shamt[5], which does not exist
  assign shamtOk = (XLEN != 32) || !dec.instr[25];

  always_comb begin
    mn = ILLEGAL;
    case (opcode)
      OPC_LUI:      mn = LUI;
      OPC_AUIPC:    mn = AUIPC;
      OPC_JAL:      mn = JAL;
      OPC_JALR:     mn = (funct3 == 3'b000) ? JALR : ILLEGAL;
      OPC_MISC_MEM: mn = (funct3 == 3'b000) ? FENCE : ILLEGAL;
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  mn = BEQ;
          3'b001:  mn = BNE;
          3'b100:  mn = BLT;
          3'b101:  mn = BGE;
          3'b110:  mn = BLTU;
          3'b111:  mn = BGEU;
          default: mn = ILLEGAL;
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  mn = LB;
          3'b001:  mn = LH;
          3'b010:  mn = LW;
          3'b100:  mn = LBU;
          3'b101:  mn = LHU;
          default: mn = ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  mn = SB;
          3'b001:  mn = SH;
          3'b010:  mn = SW;
          default: mn = ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        // funct7 only matters for the shifts
        casez ({funct7, funct3})
          10'b???????_000: mn = ADDI;
          10'b???????_010: mn = SLTI;
          10'b???????_011: mn = SLTIU;
          10'b???????_100: mn = XORI;
          10'b???????_110: mn = ORI;
          10'b???????_111: mn = ANDI;
          10'b000000?_001: mn = shamtOk ? SLLI : ILLEGAL;
          10'b000000?_101: mn = shamtOk ? SRLI : ILLEGAL;
          10'b010000?_101: mn = shamtOk ? SRAI : ILLEGAL;
          default:         mn = ILLEGAL;
        endcase
      end
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: mn = ADD;
          10'b0100000_000: mn = SUB;
          10'b0000000_001: mn = SLL;
          10'b0000000_010: mn = SLT;
          10'b0000000_011: mn = SLTU;
          10'b0000000_100: mn = XOR;
          10'b0000000_101: mn = SRL;
          10'b0100000_101: mn = SRA;
          10'b0000000_110: mn = OR;
          10'b0000000_111: mn = AND;
          10'b0000001_000: mn = MUL;
          10'b0000001_001: mn = MULH;
          10'b0000001_010: mn = MULHSU;
          10'b0000001_011: mn = MULHU;
          10'b0000001_100: mn = DIV;
          10'b0000001_101: mn = DIVU;
          10'b0000001_110: mn = REM;
          10'b0000001_111: mn = REMU;
          default:         mn = ILLEGAL;
        endcase
      end
      OPC_SYSTEM: begin
        case (funct3)
          // Privileged ops are fixed words
          3'b000: begin
            case (dec.instr)
              32'h0000_0073: mn = ECALL;
              32'h0010_0073: mn = EBREAK;
              32'h3020_0073: mn = MRET;
              32'h1050_0073: mn = WFI;
              default:       mn = ILLEGAL;
            endcase
          end
          3'b001:  mn = CSRRW;
          3'b010:  mn = CSRRS;
          3'b011:  mn = CSRRC;
          3'b101:  mn = CSRRWI;
          3'b110:  mn = CSRRSI;
          3'b111:  mn = CSRRCI;
          default: mn = ILLEGAL;
        endcase
      end
      default: mn = ILLEGAL;
    endcase
  end

  // Format follows from the mnemonic, so an illegal word lands on NONE
  always_comb begin
    case (mn)
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU:   fmt = FMT_R;
      ADDI, SLTI, SLTIU, XORI, ORI, ANDI, JALR,
      LB, LH, LW, LBU, LHU:                             fmt = FMT_I;
      SLLI, SRLI, SRAI:                                 fmt = FMT_SH;
      SB, SH, SW:                                       fmt = FMT_S;
      BEQ, BNE, BLT, BGE, BLTU, BGEU:                   fmt = FMT_B;
      LUI, AUIPC:                                       fmt = FMT_U;
      JAL:                                              fmt = FMT_J;
      CSRRW, CSRRS, CSRRC:                              fmt = FMT_CSR;
      CSRRWI, CSRRSI, CSRRCI:                           fmt = FMT_CSRI;
      default:                                          fmt = FMT_NONE;
    endcase
  end

  assign dec.mnemonic = mn;
  assign dec.fmt      = fmt;
  assign dec.illegal  = (mn == ILLEGAL);

endmodule

// ==== src/operandExtract.sv ====
`timescale 1ns/10ps

module operandExtract import rvDecodePkg::*; (
  decodeIf.extract dec
);

  instrT  ins;
  regIdxT rdField;
  regIdxT rs1Field;
  regIdxT rs2Field;
  immT    immI;
  immT    immS;
  immT    immB;
  immT    immU;
  immT    immJ;
  immT    csrAddr;
  immT    shamt;

  assign ins      = dec.instr;
  assign rdField  = ins[11:7];
  assign rs1Field = ins[19:15];
  assign rs2Field = ins[24:20];

  // Sign-extended immediates per format
  assign immI = {{20{ins[31]}}, ins[31:20]};
  assign immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign immU = {ins[31:12], 12'b0};
  assign immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  assign csrAddr = {20'b0, ins[31:20]};
  // Bit 25 is zero for any shift the matcher accepts on RV32
  assign shamt   = {26'b0, ins[25:20]};

  always_comb begin
    dec.rd  = '0;
    dec.rs1 = '0;
    dec.rs2 = '0;
    dec.imm = '0;
    case (dec.fmt)
      FMT_R: begin
        dec.rd  = rdField;
        dec.rs1 = rs1Field;
        dec.rs2 = rs2Field;
      end
      FMT_I, FMT_SH, FMT_CSR: begin
        dec.rd  = rdField;
        dec.rs1 = rs1Field;
        dec.imm = (dec.fmt == FMT_I) ? immI : (dec.fmt == FMT_SH) ? shamt : csrAddr;
      end
      FMT_S, FMT_B: begin
        dec.rs1 = rs1Field;
        dec.rs2 = rs2Field;
        dec.imm = (dec.fmt == FMT_S) ? immS : immB;
      end
      FMT_U: begin
        dec.rd  = rdField;
        dec.imm = immU;
      end
      FMT_J: begin
        dec.rd  = rdField;
        dec.imm = immJ;
      end
      FMT_CSRI: begin
        // rs1 slot holds the 5-bit zimm
        dec.rd  = rdField;
        dec.rs1 = rs1Field;
        dec.imm = csrAddr;
      end
      default: ;
    endcase
  end

endmodule

// ==== src/reqAckCtrl.sv ====
`timescale 1ns/10ps

module reqAckCtrl import rvDecodePkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     instrReq,
  input  instrT    instr,
  output logic     instrAck,
  output mnemonicT mnemonic,
  output instrFmtT fmt,
  output regIdxT   rd,
  output regIdxT   rs1,
  output regIdxT   rs2,
  output immT      imm,
  output logic     illegal,
  decodeIf.ctrl    dec
);

  typedef enum logic [1:0] {
    IDLE,
    DECODE,
    ACK
  } stateT;

  stateT state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (instrReq) state <= DECODE;
        DECODE:  state <= ACK;
        // Held request keeps the result frozen
        ACK:     if (!instrReq) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Word is taken as the request is accepted
  always_ff @(posedge clk) begin
    if (state == IDLE && instrReq) begin
      dec.instr <= instr;
    end
  end

  // Decoded record settles during DECODE
  always_ff @(posedge clk) begin
    if (rst) begin
      mnemonic <= ILLEGAL;
      fmt      <= FMT_NONE;
      rd       <= '0;
      rs1      <= '0;
      rs2      <= '0;
      imm      <= '0;
      illegal  <= 1'b0;
    end else if (state == DECODE) begin
      mnemonic <= dec.mnemonic;
      fmt      <= dec.fmt;
      rd       <= dec.rd;
      rs1      <= dec.rs1;
      rs2      <= dec.rs2;
      imm      <= dec.imm;
      illegal  <= dec.illegal;
    end
  end

  assign instrAck = (state == ACK);

endmodule

// ==== src/rvDisasmTop.sv ====
`timescale 1ns/10ps

module rvDisasmTop import rvDecodePkg::*; #(
  parameter int XLEN = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     instrReq,
  input  instrT    instr,
  output logic     instrAck,
  output mnemonicT mnemonic,
  output instrFmtT fmt,
  output regIdxT   rd,
  output regIdxT   rs1,
  output regIdxT   rs2,
  output immT      imm,
  output logic     illegal
);

  decodeIf dec ();

  reqAckCtrl uCtrl (
    .clk      (clk),
    .rst      (rst),
    .instrReq (instrReq),
    .instr    (instr),
    .instrAck (instrAck),
    .mnemonic (mnemonic),
    .fmt      (fmt),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .imm      (imm),
    .illegal  (illegal),
    .dec      (dec.ctrl)
  );

  // Matcher and extractor are combinational on the captured word
  opcodeMatcher #(.XLEN(XLEN)) uMatch (.dec(dec.match));

  operandExtract uExtract (.dec(dec.extract));

endmodule

// ==== tb/reqAck_chk.sv ====
`timescale 1ns/10ps

module reqAck_chk import rvDecodePkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     instrReq,
  input logic     instrAck,
  input mnemonicT mnemonic,
  input instrFmtT fmt,
  input regIdxT   rd,
  input regIdxT   rs1,
  input regIdxT   rs2,
  input immT      imm,
  input logic     illegal
);

  logic [58:0] record;

  assign record = {mnemonic, fmt, rd, rs1, rs2, imm, illegal};

  // Ack only answers a pending request
  ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
    $rose(instrAck) |-> $past(instrReq))
    else $error("instrAck rose without a pending request");

  ackHeld: assert property (@(posedge clk) disable iff (rst)
    instrAck && instrReq |=> instrAck)
    else $error("instrAck dropped while instrReq was still high");

  // Result registers frozen while acknowledged
  outStable: assert property (@(posedge clk) disable iff (rst)
    instrAck |=> $stable(record))
    else $error("decoded outputs changed while instrAck was high");

  ackLowAfterReset: assert property (@(posedge clk) rst |=> !instrAck)
    else $error("instrAck high in the cycle after reset");

endmodule

bind reqAckCtrl reqAck_chk uChk (
  .clk      (clk),
  .rst      (rst),
  .instrReq (instrReq),
  .instrAck (instrAck),
  .mnemonic (mnemonic),
  .fmt      (fmt),
  .rd       (rd),
  .rs1      (rs1),
  .rs2      (rs2),
  .imm      (imm),
  .illegal  (illegal)
);

// ==== tb/rvDisasmTb.sv ====
`timescale 1ns/10ps

module rvDisasmTb import rvDecodePkg::*; ();

  localparam int NUM_RANDOM = 20;

  typedef struct packed {
    instrT    word;
    mnemonicT mn;
    instrFmtT fmt;
    regIdxT   rd;
    regIdxT   rs1;
    regIdxT   rs2;
    immT      imm;
    logic     ill;
  } vecT;

  logic     clk;
  logic     rst;
  logic     instrReq;
  instrT    instr;
  logic     instrAck;
  mnemonicT mnemonic;
  instrFmtT fmt;
  regIdxT   rd;
  regIdxT   rs1;
  regIdxT   rs2;
  immT      imm;
  logic     illegal;

  vecT   vecs[$];
  string names[$];
  int    cycles;
  int    cycleLimit;

  rvDisasmTop #(.XLEN(32)) dut (
    .clk      (clk),
    .rst      (rst),
    .instrReq (instrReq),
    .instr    (instr),
    .instrAck (instrAck),
    .mnemonic (mnemonic),
    .fmt      (fmt),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .imm      (imm),
    .illegal  (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic reportError(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopping at first error");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      reportError($sformatf("Timeout: run exceeded %0d clock cycles", cycleLimit));
    end
  end

  // Standard RV32 encodings
  function automatic instrT encodeR(input logic [6:0] f7, input logic [4:0] s2,
                                    input logic [4:0] s1, input logic [2:0] f3,
                                    input logic [4:0] d, input logic [6:0] op);
    return {f7, s2, s1, f3, d, op};
  endfunction

  function automatic instrT encodeI(input logic [31:0] i, input logic [4:0] s1,
                                    input logic [2:0] f3, input logic [4:0] d,
                                    input logic [6:0] op);
    return {i[11:0], s1, f3, d, op};
  endfunction

  function automatic instrT encodeS(input logic [31:0] i, input logic [4:0] s2,
                                    input logic [4:0] s1, input logic [2:0] f3,
                                    input logic [6:0] op);
    return {i[11:5], s2, s1, f3, i[4:0], op};
  endfunction

  function automatic instrT encodeB(input logic [31:0] i, input logic [4:0] s2,
                                    input logic [4:0] s1, input logic [2:0] f3,
                                    input logic [6:0] op);
    return {i[12], i[10:5], s2, s1, f3, i[4:1], i[11], op};
  endfunction

  function automatic instrT encodeU(input logic [31:0] i, input logic [4:0] d,
                                    input logic [6:0] op);
    return {i[31:12], d, op};
  endfunction

  function automatic instrT encodeJ(input logic [31:0] i, input logic [4:0] d,
                                    input logic [6:0] op);
    return {i[20], i[10:1], i[11], i[19:12], d, op};
  endfunction

  function automatic vecT makeVec(input instrT w, input mnemonicT m, input instrFmtT f,
                                  input regIdxT d, input regIdxT s1, input regIdxT s2,
                                  input immT i, input logic il);
    return '{word: w, mn: m, fmt: f, rd: d, rs1: s1, rs2: s2, imm: i, ill: il};
  endfunction

  task automatic addCase(input string n, input instrT w, input mnemonicT m,
                         input instrFmtT f, input regIdxT d, input regIdxT s1,
                         input regIdxT s2, input immT i, input logic il);
    names.push_back(n);
    vecs.push_back(makeVec(w, m, f, d, s1, s2, i, il));
  endtask

  task automatic buildTable();
    addCase("add", encodeR(7'h00, 2, 1, 3'b000, 3, OPC_OP), ADD, FMT_R, 3, 1, 2, 0, 0);
    addCase("sub", encodeR(7'h20, 7, 6, 3'b000, 5, OPC_OP), SUB, FMT_R, 5, 6, 7, 0, 0);
    addCase("mul", encodeR(7'h01, 12, 11, 3'b000, 10, OPC_OP), MUL, FMT_R, 10, 11, 12, 0, 0);
    addCase("divu", encodeR(7'h01, 29, 30, 3'b101, 31, OPC_OP), DIVU, FMT_R, 31, 30, 29, 0, 0);
    addCase("lw", encodeI(-4, 2, 3'b010, 8, OPC_LOAD), LW, FMT_I, 8, 2, 0, -4, 0);
    addCase("addi", encodeI(2047, 0, 3'b000, 1, OPC_OP_IMM), ADDI, FMT_I, 1, 0, 0, 2047, 0);
    addCase("srai", encodeI(32'h41F, 5, 3'b101, 4, OPC_OP_IMM), SRAI, FMT_SH, 4, 5, 0, 31, 0);
    addCase("sb", encodeS(-1, 9, 10, 3'b000, OPC_STORE), SB, FMT_S, 0, 10, 9, -1, 0);
    addCase("bne", encodeB(-8, 2, 1, 3'b001, OPC_BRANCH), BNE, FMT_B, 0, 1, 2, -8, 0);
    addCase("lui", encodeU(32'hABCDE000, 7, OPC_LUI), LUI, FMT_U, 7, 0, 0, 32'hABCDE000, 0);
    addCase("auipc", encodeU(32'h1000, 2, OPC_AUIPC), AUIPC, FMT_U, 2, 0, 0, 32'h1000, 0);
    addCase("jal", encodeJ(-2048, 1, OPC_JAL), JAL, FMT_J, 1, 0, 0, -2048, 0);
    addCase("jalr", encodeI(16, 1, 3'b000, 0, OPC_JALR), JALR, FMT_I, 0, 1, 0, 16, 0);
    addCase("csrrw", encodeI(32'h300, 6, 3'b001, 5, OPC_SYSTEM), CSRRW, FMT_CSR,
            5, 6, 0, 32'h300, 0);
    // CSR address with bit 11 set stays zero-extended
    addCase("csrrsi", encodeI(32'hF14, 7, 3'b110, 3, OPC_SYSTEM), CSRRSI, FMT_CSRI,
            3, 7, 0, 32'hF14, 0);
    addCase("fence", encodeI(32'h0FF, 0, 3'b000, 0, OPC_MISC_MEM), FENCE, FMT_NONE,
            0, 0, 0, 0, 0);
    addCase("ecall", 32'h0000_0073, ECALL, FMT_NONE, 0, 0, 0, 0, 0);
    addCase("mret", 32'h3020_0073, MRET, FMT_NONE, 0, 0, 0, 0, 0);
    addCase("wfi", 32'h1050_0073, WFI, FMT_NONE, 0, 0, 0, 0, 0);
    addCase("bad opcode", 32'hFFFF_FFFF, ILLEGAL, FMT_NONE, 0, 0, 0, 0, 1);
    addCase("srli mfunct7", encodeI(32'h025, 2, 3'b101, 2, OPC_OP_IMM), ILLEGAL, FMT_NONE,
            0, 0, 0, 0, 1);
    addCase("slli bit25", encodeI(32'h020, 1, 3'b001, 1, OPC_OP_IMM), ILLEGAL, FMT_NONE,
            0, 0, 0, 0, 1);
  endtask

  task automatic checkMnemonic(input string name, input mnemonicT exp, input mnemonicT act);
    if (exp !== act) begin
      reportError($sformatf("FAIL %s mnemonic: expected %s actual %s",
                            name, exp.name(), act.name()));
    end
  endtask

  task automatic checkFmt(input string name, input instrFmtT exp, input instrFmtT act);
    if (exp !== act) begin
      reportError($sformatf("FAIL %s fmt: expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic checkReg(input string name, input regIdxT exp, input regIdxT act);
    if (exp !== act) begin
      reportError($sformatf("FAIL %s: expected x%0d actual x%0d", name, exp, act));
    end
  endtask

  task automatic checkImm(input string name, input immT exp, input immT act);
    if (exp !== act) begin
      reportError($sformatf("FAIL %s imm: expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      reportError($sformatf("FAIL %s: expected %b actual %b", name, exp, act));
    end
  endtask

  // One four-phase transaction with an optional held request after ack
  task automatic runCase(input string name, input vecT v, input int holdCycles);
    int edges;
    @(posedge clk);
    #1;
    instr    = v.word;
    instrReq = 1'b1;
    edges    = 0;
    while (!instrAck) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (edges != 2) begin
      reportError($sformatf("%s: instrAck rose after %0d edges instead of 2", name, edges));
    end
    repeat (holdCycles) begin
      @(posedge clk);
      #1;
      if (!instrAck) begin
        reportError($sformatf("%s: instrAck dropped under a held request", name));
      end
    end
    checkMnemonic(name, v.mn, mnemonic);
    checkFmt(name, v.fmt, fmt);
    checkReg({name, " rd"}, v.rd, rd);
    checkReg({name, " rs1"}, v.rs1, rs1);
    checkReg({name, " rs2"}, v.rs2, rs2);
    checkImm(name, v.imm, imm);
    checkFlag({name, " illegal"}, v.ill, illegal);
    instrReq = 1'b0;
    edges    = 0;
    while (instrAck) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (edges != 1) begin
      reportError($sformatf("%s: instrAck fell %0d edges after release", name, edges));
    end
  endtask

  initial begin
    vecT         v;
    logic [31:0] r;
    immT         off;
    immT         boff;
    regIdxT      d;
    regIdxT      s1;
    regIdxT      s2;
    instrReq   = 1'b0;
    instr      = '0;
    rst        = 1'b1;
    cycles     = 0;
    cycleLimit = 0;
    r = $urandom(41907);
    buildTable();
    cycleLimit = (vecs.size() + NUM_RANDOM) * 8 + 50;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    checkFlag("reset instrAck", 1'b0, instrAck);
    checkMnemonic("reset", ILLEGAL, mnemonic);
    checkFmt("reset", FMT_NONE, fmt);
    foreach (vecs[i]) begin
      runCase(names[i], vecs[i], (i == 0) ? 3 : 0);
    end
    // Random operands for add, addi, sw and beq
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r    = $urandom();
      d    = r[4:0];
      s1   = r[9:5];
      s2   = r[14:10];
      off  = {{20{r[31]}}, r[31:20]};
      boff = {{19{r[31]}}, r[31:20], 1'b0};
      case (i % 4)
        0: v = makeVec(encodeR(7'h00, s2, s1, 3'b000, d, OPC_OP), ADD, FMT_R, d, s1, s2, 0, 0);
        1: v = makeVec(encodeI(off, s1, 3'b000, d, OPC_OP_IMM), ADDI, FMT_I, d, s1, 0, off, 0);
        2: v = makeVec(encodeS(off, s2, s1, 3'b010, OPC_STORE), SW, FMT_S, 0, s1, s2, off, 0);
        default: v = makeVec(encodeB(boff, s2, s1, 3'b000, OPC_BRANCH), BEQ, FMT_B,
                             0, s1, s2, boff, 0);
      endcase
      runCase($sformatf("random %0d", i), v, 0);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== tb.f ====
src/rvDecodePkg.sv
src/decodeIf.sv
src/opcodeMatcher.sv
src/operandExtract.sv
src/reqAckCtrl.sv
src/rvDisasmTop.sv
tb/reqAck_chk.sv
tb/rvDisasmTb.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/VrvDisasmTb
	@out="$$(./obj_dir/VrvDisasmTb)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

# Rebuilt only when a source or the file list changes
obj_dir/VrvDisasmTb: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module rvDisasmTb

clean:
	rm -rf obj_dir
